/* fp_minmax_lane.sv */
// One SIMD lane: RISC-V style FMIN/FMAX on FP32 or FP16 operands,
// followed by the lane's share of the valid/ready pipeline

`timescale 1ns/100ps
`include "fp_slice_config.svh"

module fp_minmax_lane import fp_slice_pkg::*; #(
  parameter bit LaneHasFp32 = 1'b1
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  input  operation_e  op_i,
  input  fp_format_e  fmt_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output lane_res_t   res_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  localparam logic [31:0] CanonNan32 = 32'h7fc0_0000;
  localparam logic [15:0] CanonNan16 = 16'h7e00;

  logic        is_fp32;
  logic        sign_a, sign_b;
  logic [30:0] mag_a, mag_b;
  logic        nan_a, nan_b, snan_a, snan_b;
  logic        a_lt_b;
  logic [31:0] sel;
  lane_res_t   res_d;

  // Lanes without FP32 support always work on FP16
  assign is_fp32 = LaneHasFp32 && (fmt_i == FP32);

  // ------------------------------------------------------------
  // Classification and compare
  // ------------------------------------------------------------
  always_comb begin : classify
    sign_a = is_fp32 ? a_i[31] : a_i[15];
    sign_b = is_fp32 ? b_i[31] : b_i[15];
    mag_a  = is_fp32 ? a_i[30:0] : {16'h0, a_i[14:0]};
    mag_b  = is_fp32 ? b_i[30:0] : {16'h0, b_i[14:0]};
    if (is_fp32) begin
      nan_a  = (a_i[30:23] == 8'hff) && (a_i[22:0] != '0);
      nan_b  = (b_i[30:23] == 8'hff) && (b_i[22:0] != '0);
      snan_a = nan_a & ~a_i[22];   // Quiet bit clear
      snan_b = nan_b & ~b_i[22];
    end else begin
      nan_a  = (a_i[14:10] == 5'h1f) && (a_i[9:0] != '0);
      nan_b  = (b_i[14:10] == 5'h1f) && (b_i[9:0] != '0);
      snan_a = nan_a & ~a_i[9];
      snan_b = nan_b & ~b_i[9];
    end
    // Sign-magnitude order, -0 sorts below +0 via the sign test
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin : select_result
    if (nan_a && nan_b) begin
      sel = is_fp32 ? CanonNan32 : {16'hffff, CanonNan16};
    end else if (nan_a) begin
      sel = b_i;
    end else if (nan_b) begin
      sel = a_i;
    end else if ((op_i == MIN) == a_lt_b) begin
      sel = a_i;
    end else begin
      sel = b_i;
    end
    res_d.result    = is_fp32 ? sel : {16'hffff, sel[15:0]};
    res_d.status    = '0;
    res_d.status.nv = snan_a | snan_b;   // Only flag min/max can raise
  end

  // ------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------
  logic      stage_valid [`NUM_PIPE_REGS+1];
  logic      stage_ready [`NUM_PIPE_REGS+1];
  lane_res_t stage_data  [`NUM_PIPE_REGS+1];

  assign stage_valid[0] = in_valid_i;
  assign stage_data[0]  = res_d;
  assign in_ready_o     = stage_ready[0];

  for (genvar s = 0; s < `NUM_PIPE_REGS; s++) begin : gen_stage
    fp_pipe_stage #(
      .payload_t ( lane_res_t )
    ) stage_i (
      .clk_i   ( clk_i            ),
      .rst_n_i ( rst_n_i          ),
      .valid_i ( stage_valid[s]   ),
      .ready_o ( stage_ready[s]   ),
      .data_i  ( stage_data[s]    ),
      .valid_o ( stage_valid[s+1] ),
      .ready_i ( stage_ready[s+1] ),
      .data_o  ( stage_data[s+1]  )
    );
  end

  assign stage_ready[`NUM_PIPE_REGS] = out_ready_i;
  assign out_valid_o = stage_valid[`NUM_PIPE_REGS];
  assign res_o       = stage_data[`NUM_PIPE_REGS];

endmodule

/* fp_minmax_slice.sv */
// SIMD floating-point min/max slice, top level
// Operands in, packed results out, both over valid/ready with a tag

`timescale 1ns/100ps
`include "fp_slice_config.svh"

module fp_minmax_slice import fp_slice_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Request
  input  logic [`SLICE_WIDTH-1:0] operands_a_i,
  input  logic [`SLICE_WIDTH-1:0] operands_b_i,
  input  operation_e              op_i,
  input  fp_format_e              fmt_i,
  input  logic                    vectorial_i,
  input  lane_mask_t              simd_mask_i,
  input  tag_t                    tag_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  // Response
  output logic [`SLICE_WIDTH-1:0] result_o,
  output status_t                 status_o,
  output tag_t                    tag_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  logic [NUM_LANES-1:0][31:0] lane_a, lane_b;
  lane_mask_t                 in_lane_valid;
  side_t                      in_side;

  lane_res_t [NUM_LANES-1:0]  out_lane_res;
  lane_mask_t                 out_lane_valid;
  side_t                      out_side;

  fp_slice_decode decode_i (
    .operands_a_i ( operands_a_i  ),
    .operands_b_i ( operands_b_i  ),
    .fmt_i        ( fmt_i         ),
    .vectorial_i  ( vectorial_i   ),
    .simd_mask_i  ( simd_mask_i   ),
    .tag_i        ( tag_i         ),
    .in_valid_i   ( in_valid_i    ),
    .lane_a_o     ( lane_a        ),
    .lane_b_o     ( lane_b        ),
    .lane_valid_o ( in_lane_valid ),
    .side_o       ( in_side       )
  );

  fp_slice_execute execute_i (
    .clk_i        ( clk_i          ),
    .rst_n_i      ( rst_n_i        ),
    .lane_a_i     ( lane_a         ),
    .lane_b_i     ( lane_b         ),
    .lane_valid_i ( in_lane_valid  ),
    .op_i         ( op_i           ),
    .fmt_i        ( fmt_i          ),
    .side_i       ( in_side        ),
    .in_ready_o   ( in_ready_o     ),
    .lane_res_o   ( out_lane_res   ),
    .lane_valid_o ( out_lane_valid ),
    .side_o       ( out_side       ),
    .out_valid_o  ( out_valid_o    ),
    .out_ready_i  ( out_ready_i    ),
    .busy_o       ( busy_o         )
  );

  fp_slice_result result_i (
    .lane_res_i   ( out_lane_res   ),
    .lane_valid_i ( out_lane_valid ),
    .side_i       ( out_side       ),
    .result_o     ( result_o       ),
    .status_o     ( status_o       ),
    .tag_o        ( tag_o          )
  );

endmodule

/* fp_pipe_stage.sv */
// One valid/ready register stage for any payload type
// Chain several of these to build a pipeline with back-pressure

`timescale 1ns/100ps

module fp_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Take new data when empty or when the held item leaves
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // A stalled item must not change under the consumer
  a_hold_stalled : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(data_o));

endmodule

/* fp_slice_config.svh */
// Build-time sizing of the SIMD min/max slice
// Pulled in by the package and by every module that sizes ports or pipes

`ifndef FP_SLICE_CONFIG_SVH
`define FP_SLICE_CONFIG_SVH

// Operand and result word width, cut into 16-bit lanes
`define SLICE_WIDTH 64

// Register stages in every lane and in the side pipeline
`define NUM_PIPE_REGS 2

// Width of the operation tag
`define TAG_WIDTH 4

`endif

/* fp_slice_decode.sv */
// Input side of the slice: cuts both operands into lanes by format
// and works out which lanes take part in the operation

`timescale 1ns/100ps
`include "fp_slice_config.svh"

module fp_slice_decode import fp_slice_pkg::*; (
  input  logic [`SLICE_WIDTH-1:0]        operands_a_i,
  input  logic [`SLICE_WIDTH-1:0]        operands_b_i,
  input  fp_format_e                     fmt_i,
  input  logic                           vectorial_i,
  input  lane_mask_t                     simd_mask_i,
  input  tag_t                           tag_i,
  input  logic                           in_valid_i,
  output logic [NUM_LANES-1:0][31:0]     lane_a_o,
  output logic [NUM_LANES-1:0][31:0]     lane_b_o,
  output lane_mask_t                     lane_valid_o,
  output side_t                          side_o
);

  // Lane stride in bits for the current format
  logic [5:0] lane_width;

  assign lane_width = (fmt_i == FP32) ? 6'd32 : 6'd16;

  // ------------------------------------------------------------
  // Operand slicing
  // ------------------------------------------------------------
  always_comb begin : slice_operands
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      // Upper bits past the format width are ignored by the lane
      lane_a_o[l] = 32'(operands_a_i >> (l * lane_width));
      lane_b_o[l] = 32'(operands_b_i >> (l * lane_width));
    end
  end

  // ------------------------------------------------------------
  // Lane valids
  // ------------------------------------------------------------
  always_comb begin : build_valids
    lane_valid_o[0] = in_valid_i;   // Scalar ops live in lane 0
    for (int unsigned l = 1; l < NUM_LANES; l++) begin
      lane_valid_o[l] = in_valid_i & vectorial_i
                        & ((fmt_i == FP16) | (l < NUM_LANES / 2));
    end
  end

  assign side_o.tag       = tag_i;
  assign side_o.fmt       = fmt_i;
  assign side_o.vectorial = vectorial_i;
  assign side_o.mask      = simd_mask_i;

endmodule

/* fp_slice_execute.sv */
// Execution core of the slice: all lanes plus the side-data pipeline
// Lane 0 and the side pipeline carry every item, upper lanes only vector items

`timescale 1ns/100ps
`include "fp_slice_config.svh"

module fp_slice_execute import fp_slice_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [NUM_LANES-1:0][31:0] lane_a_i,
  input  logic [NUM_LANES-1:0][31:0] lane_b_i,
  input  lane_mask_t                 lane_valid_i,
  input  operation_e                 op_i,
  input  fp_format_e                 fmt_i,
  input  side_t                      side_i,
  output logic                       in_ready_o,
  output lane_res_t [NUM_LANES-1:0]  lane_res_o,
  output lane_mask_t                 lane_valid_o,
  output side_t                      side_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       busy_o
);

  logic      lane_in_valid  [NUM_LANES];
  logic      lane_in_ready  [NUM_LANES];
  logic      lane_out_valid [NUM_LANES];
  logic      lane_out_ready [NUM_LANES];
  lane_res_t lane_res       [NUM_LANES];
  logic      lane_used      [NUM_LANES];

  logic  side_valid [`NUM_PIPE_REGS+1];
  logic  side_ready [`NUM_PIPE_REGS+1];
  side_t side_data  [`NUM_PIPE_REGS+1];

  // ------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
    // Does the item at the output occupy this lane
    assign lane_used[l] = (l == 0) | (side_o.vectorial
                          & ((side_o.fmt == FP16) | (l < NUM_LANES / 2)));
    assign lane_out_ready[l] = out_ready_i & lane_used[l];

    // Upper lanes take an item only on the edge where lane 0 takes it
    assign lane_in_valid[l] = lane_valid_i[l] & ((l == 0) | in_ready_o);

    fp_minmax_lane #(
      .LaneHasFp32 ( l < NUM_LANES / 2 )
    ) lane_i (
      .clk_i       ( clk_i             ),
      .rst_n_i     ( rst_n_i           ),
      .a_i         ( lane_a_i[l]       ),
      .b_i         ( lane_b_i[l]       ),
      .op_i        ( op_i              ),
      .fmt_i       ( fmt_i             ),
      .in_valid_i  ( lane_in_valid[l]  ),
      .in_ready_o  ( lane_in_ready[l]  ),
      .res_o       ( lane_res[l]       ),
      .out_valid_o ( lane_out_valid[l] ),
      .out_ready_i ( lane_out_ready[l] )
    );

    assign lane_res_o[l]   = lane_res[l];
    assign lane_valid_o[l] = lane_out_valid[l] & lane_used[l];

    // An upper lane never runs fuller than lane 0
    if (l > 0) begin : gen_upper_check
      a_upper_ready : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        lane_valid_i[l] && in_ready_o |-> lane_in_ready[l]);
    end
  end

  assign in_ready_o  = lane_in_ready[0];  // Upstream ready from lane 0
  assign out_valid_o = lane_out_valid[0];

  // ------------------------------------------------------------
  // Side pipeline
  // ------------------------------------------------------------
  assign side_valid[0] = lane_valid_i[0];
  assign side_data[0]  = side_i;

  for (genvar s = 0; s < `NUM_PIPE_REGS; s++) begin : gen_side_stage
    fp_pipe_stage #(
      .payload_t ( side_t )
    ) side_stage_i (
      .clk_i   ( clk_i           ),
      .rst_n_i ( rst_n_i         ),
      .valid_i ( side_valid[s]   ),
      .ready_o ( side_ready[s]   ),
      .data_i  ( side_data[s]    ),
      .valid_o ( side_valid[s+1] ),
      .ready_i ( side_ready[s+1] ),
      .data_o  ( side_data[s+1]  )
    );
  end

  assign side_ready[`NUM_PIPE_REGS] = out_ready_i;
  assign side_o = side_data[`NUM_PIPE_REGS];

  // Side stages see every item in flight
  always_comb begin : busy_collapse
    busy_o = 1'b0;
    for (int s = 1; s <= `NUM_PIPE_REGS; s++) begin
      busy_o |= side_valid[s];
    end
  end

  // Side pipeline mirrors lane 0 in both directions
  a_side_sync : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (side_valid[`NUM_PIPE_REGS] == lane_out_valid[0])
    && (side_ready[0] == lane_in_ready[0]));

endmodule

/* fp_slice_pkg.sv */
// Shared types of the SIMD min/max slice
// Modules take these by a wildcard import in their header

`include "fp_slice_config.svh"

package fp_slice_pkg;

  // One lane per 16 bits of the slice
  localparam int unsigned NUM_LANES = `SLICE_WIDTH / 16;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    MIN = 1'b0,
    MAX = 1'b1
  } operation_e;

  // IEEE exception flags, same order as fflags
  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  typedef logic [`TAG_WIDTH-1:0] tag_t;
  typedef logic [NUM_LANES-1:0]  lane_mask_t;

  // Payload of one lane stage
  typedef struct packed {
    logic [31:0] result;
    status_t     status;
  } lane_res_t;

  // Data carried alongside the lanes
  typedef struct packed {
    tag_t       tag;
    fp_format_e fmt;
    logic       vectorial;
    lane_mask_t mask;
  } side_t;

endpackage

/* fp_slice_result.sv */
// Output side of the slice: packs lane results into the result word
// with NaN-boxing and collapses lane status under the SIMD mask

`timescale 1ns/100ps
`include "fp_slice_config.svh"

module fp_slice_result import fp_slice_pkg::*; (
  input  lane_res_t [NUM_LANES-1:0] lane_res_i,
  input  lane_mask_t                lane_valid_i,
  input  side_t                     side_i,
  output logic [`SLICE_WIDTH-1:0]   result_o,
  output status_t                   status_o,
  output logic [`TAG_WIDTH-1:0]     tag_o
);

  // ------------------------------------------------------------
  // Result packing
  // ------------------------------------------------------------
  always_comb begin : pack_result
    result_o = '1;   // Unused positions stay NaN-boxed
    if (side_i.fmt == FP32) begin
      for (int unsigned l = 0; l < NUM_LANES / 2; l++) begin
        if (lane_valid_i[l]) begin
          result_o[32*l +: 32] = lane_res_i[l].result;
        end
      end
    end else begin
      for (int unsigned l = 0; l < NUM_LANES; l++) begin
        if (lane_valid_i[l]) begin
          result_o[16*l +: 16] = lane_res_i[l].result[15:0];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Status collapse
  // ------------------------------------------------------------
  always_comb begin : collapse_status
    status_o = '0;
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      // Masked-off lanes raise nothing
      if (lane_valid_i[l] && side_i.mask[l]) begin
        status_o |= lane_res_i[l].status;
      end
    end
  end

  assign tag_o = side_i.tag;

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f \
  --top-module tb_fp_minmax_slice -o tb_fp_minmax_slice &&
./obj_dir/tb_fp_minmax_slice || exit 1

/* sim.f */
+incdir+.
fp_slice_pkg.sv
fp_pipe_stage.sv
fp_slice_decode.sv
fp_minmax_lane.sv
fp_slice_execute.sv
fp_slice_result.sv
fp_minmax_slice.sv
tb_fp_minmax_slice.sv

/* tb_fp_minmax_slice.sv */
// Testbench for the SIMD min/max slice
// Streams a table of rows through the DUT twice: once with the output always
// ready and fixed latency checks, once with random output stalls

`timescale 1ns/100ps
`include "fp_slice_config.svh"

module tb_fp_minmax_slice import fp_slice_pkg::*; ();

  localparam int NUM_ROWS   = 14;
  localparam int WAIT_LIMIT = 100;   // Cycles before a wait gives up

  typedef struct packed {
    operation_e              op;
    fp_format_e              fmt;
    logic                    vec;
    lane_mask_t              mask;
    logic [`SLICE_WIDTH-1:0] a;
    logic [`SLICE_WIDTH-1:0] b;
    logic [`SLICE_WIDTH-1:0] exp_res;
    status_t                 exp_status;
  } row_t;

  // op, fmt, vec, mask, operand a, operand b, expected result, expected status
  localparam row_t ROWS [NUM_ROWS] = '{
    '{MIN, FP32, 1'b0, 4'hf, 64'h1234_5678_3f80_0000, 64'h0000_0000_4000_0000,
      64'hffff_ffff_3f80_0000, 5'h00},
    '{MAX, FP32, 1'b0, 4'hf, 64'h0000_0000_bfc0_0000, 64'h0000_0000_c040_0000,
      64'hffff_ffff_bfc0_0000, 5'h00},
    '{MIN, FP32, 1'b0, 4'hf, 64'h0000_0000_0000_0000, 64'h0000_0000_8000_0000,
      64'hffff_ffff_8000_0000, 5'h00},   // -0 below +0
    '{MAX, FP32, 1'b0, 4'hf, 64'h0000_0000_8000_0000, 64'h0000_0000_0000_0000,
      64'hffff_ffff_0000_0000, 5'h00},
    '{MAX, FP16, 1'b1, 4'hf, 64'h7c00_8000_c000_3c00, 64'hbc00_0000_3800_4000,
      64'h7c00_0000_3800_4000, 5'h00},
    '{MIN, FP32, 1'b1, 4'hf, 64'hc040_0000_4000_0000, 64'h3f80_0000_3f80_0000,
      64'hc040_0000_3f80_0000, 5'h00},
    '{MIN, FP32, 1'b0, 4'hf, 64'h0000_0000_7fc0_0000, 64'h0000_0000_3f80_0000,
      64'hffff_ffff_3f80_0000, 5'h00},   // One quiet NaN
    '{MAX, FP32, 1'b0, 4'hf, 64'h0000_0000_7fc1_2345, 64'h0000_0000_ffc0_0000,
      64'hffff_ffff_7fc0_0000, 5'h00},   // Two NaNs give canonical NaN
    '{MIN, FP16, 1'b1, 4'hf, 64'h7e00_7c01_7e00_3c00, 64'h7e80_3800_c000_4000,
      64'h7e00_3800_c000_3c00, 5'h10},   // sNaN in lane 2
    '{MIN, FP16, 1'b1, 4'hb, 64'h7e00_7c01_7e00_3c00, 64'h7e80_3800_c000_4000,
      64'h7e00_3800_c000_3c00, 5'h00},   // Same, lane 2 masked off
    '{MAX, FP32, 1'b1, 4'h3, 64'h7f80_0001_bf80_0000, 64'h3f80_0000_3f80_0000,
      64'h3f80_0000_3f80_0000, 5'h10},
    '{MAX, FP32, 1'b1, 4'h1, 64'h7f80_0001_bf80_0000, 64'h3f80_0000_3f80_0000,
      64'h3f80_0000_3f80_0000, 5'h00},
    '{MIN, FP16, 1'b0, 4'hf, 64'hdead_beef_0000_bc00, 64'h0000_0000_0000_3c00,
      64'hffff_ffff_ffff_bc00, 5'h00},
    '{MAX, FP32, 1'b0, 4'h1, 64'h0000_0000_7f80_0001, 64'h0000_0000_c040_0000,
      64'hffff_ffff_c040_0000, 5'h10}    // Scalar sNaN
  };

  logic                    clk_i;
  logic                    rst_n_i;
  logic [`SLICE_WIDTH-1:0] operands_a_i;
  logic [`SLICE_WIDTH-1:0] operands_b_i;
  operation_e              op_i;
  fp_format_e              fmt_i;
  logic                    vectorial_i;
  lane_mask_t              simd_mask_i;
  tag_t                    tag_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  logic [`SLICE_WIDTH-1:0] result_o;
  status_t                 status_o;
  tag_t                    tag_o;
  logic                    out_valid_o;
  logic                    out_ready_i;
  logic                    busy_o;

  integer seed = 32'hdc97_51c2;
  int     cycle_cnt = 0;
  int     accept_q [$];   // Edge index at which each row was accepted

  fp_minmax_slice fp_minmax_slice_i (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------------------------
  // Failure handling and compares
  // ----------------------------------------------------------
  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_result(string name, logic [`SLICE_WIDTH-1:0] got,
                              logic [`SLICE_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_status(string name, status_t got, status_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tag(string name, tag_t got, tag_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------
  // Driver and collector
  // ----------------------------------------------------------
  task automatic send_row(int idx);
    int waited;
    waited = 0;
    @(posedge clk_i);
    #1;
    op_i         = ROWS[idx].op;
    fmt_i        = ROWS[idx].fmt;
    vectorial_i  = ROWS[idx].vec;
    simd_mask_i  = ROWS[idx].mask;
    operands_a_i = ROWS[idx].a;
    operands_b_i = ROWS[idx].b;
    tag_i        = tag_t'(idx);
    in_valid_i   = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Row %0d was never accepted by the DUT", idx);
        stop_run();
      end
      @(negedge clk_i);
    end
    accept_q.push_back(cycle_cnt + 1);   // Taken at the coming edge
  endtask

  task automatic collect_row(int idx, bit stall);
    int waited;
    int rnd;
    int latency;
    bit got;
    waited = 0;
    got    = 1'b0;
    while (!got) begin
      @(posedge clk_i);
      #1;
      rnd = $random(seed);
      out_ready_i = stall ? (rnd[0] | rnd[1]) : 1'b1;
      @(negedge clk_i);
      got = out_valid_o && out_ready_i;
      waited++;
      if (!got && waited > WAIT_LIMIT) begin
        $display("Row %0d never came out of the DUT", idx);
        stop_run();
      end
    end
    check_result($sformatf("result_o (row %0d)", idx), result_o, ROWS[idx].exp_res);
    check_status($sformatf("status_o (row %0d)", idx), status_o, ROWS[idx].exp_status);
    check_tag($sformatf("tag_o (row %0d)", idx), tag_o, tag_t'(idx));
    latency = cycle_cnt + 1 - accept_q.pop_front();
    if (!stall && latency != `NUM_PIPE_REGS) begin
      $display("Row %0d came out %0d cycles after acceptance instead of %0d",
               idx, latency, `NUM_PIPE_REGS);
      stop_run();
    end
  endtask

  task automatic run_pass(bit stall);
    accept_q.delete();
    fork
      begin : drive_rows
        for (int i = 0; i < NUM_ROWS; i++) begin
          send_row(i);
        end
        @(posedge clk_i);
        #1;
        in_valid_i = 1'b0;
      end
      begin : collect_rows
        for (int i = 0; i < NUM_ROWS; i++) begin
          collect_row(i, stall);
        end
      end
    join
    @(posedge clk_i);
    #1;
    out_ready_i = 1'b1;
    @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);   // Pipeline drained
    check_flag("out_valid_o", out_valid_o, 1'b0);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    operands_a_i = '0;
    operands_b_i = '0;
    op_i         = MIN;
    fmt_i        = FP32;
    vectorial_i  = 1'b0;
    simd_mask_i  = '0;
    tag_i        = '0;
    in_valid_i   = 1'b0;
    out_ready_i  = 1'b1;

    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("in_ready_o", in_ready_o, 1'b1);

    run_pass(1'b0);   // Back to back, fixed latency
    run_pass(1'b1);   // Random output stalls

    $display("Everything OK");
    $finish;
  end

endmodule
